//--- hw/cache_pkg.sv
`default_nettype none

package cache_pkg;

// --------------------
// Geometry
// --------------------

// Total data capacity in bytes
localparam int CACHE_BYTES    = 1024;
localparam int LINE_BYTES     = 16;
localparam int WORDS_PER_LINE = LINE_BYTES / 4;
localparam int NUM_LINES      = CACHE_BYTES / LINE_BYTES;

// Dirty bits are searched this many sets at a time
localparam int SCAN_BLOCK     = 16;
localparam int NUM_BLOCKS     = NUM_LINES / SCAN_BLOCK;

// Address split into tag, index and byte offset
localparam int OFFSET_W       = $clog2(LINE_BYTES);
localparam int INDEX_W        = $clog2(NUM_LINES);

// --------------------
// Types
// --------------------

typedef logic [INDEX_W-1:0]      index_t;
typedef logic [31:0]             word_t;
typedef logic [LINE_BYTES*8-1:0] line_t;
typedef logic [LINE_BYTES-1:0]   line_ben_t;
typedef logic [NUM_LINES-1:0]    line_vec_t;
typedef logic [2:0]              cti_t;

// Virtual tag for the hit check and physical line address for write back
typedef struct packed {
        logic [31-INDEX_W-OFFSET_W:0] va_tag;
        logic [31-OFFSET_W:0]         pa_line;
} tag_entry_t;

// Wishbone cycle type codes
localparam cti_t CTI_CLASSIC = 3'b000;
localparam cti_t CTI_BURST   = 3'b010;
localparam cti_t CTI_EOB     = 3'b111;

endpackage

`default_nettype wire

//--- hw/tag_ram_if.sv
`default_nettype none

// Strobes and indexes from the controller to the RAMs and state bits
interface tag_ram_if;

// Lookup index in idle, dirty set under clean otherwise
cache_pkg::index_t rd_idx;
// Always the index of the current address
cache_pkg::index_t wr_idx;
// Tag write with valid and dirty update
logic              wr_en;
// Drops the dirty bit at rd_idx
logic              clean;
// Drops every valid bit
logic              clear;

modport ctrl (
        output rd_idx,
        output wr_idx,
        output wr_en,
        output clean,
        output clear
);

modport store (
        input rd_idx,
        input wr_idx,
        input wr_en,
        input clean,
        input clear
);

endinterface

`default_nettype wire

//--- hw/line_ram.sv
`default_nettype none

// One entry per set, written at wr_idx and read at rd_idx
module line_ram #(
        parameter type payload_t = logic [7:0]
) (
        input  wire logic     i_clk,
        tag_ram_if.store      bus,
        input  wire logic     i_wr_en,
        input  wire payload_t i_wr_data,
        output payload_t      o_rd_data
);

payload_t mem [cache_pkg::NUM_LINES];

// --------------------
// Write port
// --------------------

always_ff @(posedge i_clk)
begin
        if (i_wr_en)
                mem[bus.wr_idx] <= i_wr_data;
end

// --------------------
// Read port
// --------------------

// One cycle latency, old data on a same-index write
always_ff @(posedge i_clk)
begin
        o_rd_data <= mem[bus.rd_idx];
end

endmodule

`default_nettype wire

//--- hw/line_state.sv
`default_nettype none

// Valid and dirty bits for every set
module line_state (
        input  wire logic            i_clk,
        input  wire logic            i_reset,
        tag_ram_if.store             bus,
        input  wire logic            i_dirty,
        output logic                 o_valid,
        output logic                 o_dirty,
        output cache_pkg::line_vec_t o_dirty_vec
);

cache_pkg::line_vec_t valid;
cache_pkg::line_vec_t dirty;
logic                 fwd;

// Same-cycle write to the index being read
assign fwd         = bus.wr_en && (bus.rd_idx == bus.wr_idx);
// Scanned by the clean logic
assign o_dirty_vec = dirty;

// --------------------
// Bit arrays
// --------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                valid <= '0;
                dirty <= '0;
        end
        else
        begin
                // Invalidate wins over a tag write
                if (bus.clear)
                        valid <= '0;
                else if (bus.wr_en)
                        valid[bus.wr_idx] <= 1'b1;

                // Load on tag write, drop once the line is written back
                if (bus.wr_en)
                        dirty[bus.wr_idx] <= i_dirty;
                else if (bus.clean)
                        dirty[bus.rd_idx] <= 1'b0;
        end
end

// --------------------
// Lookup read
// --------------------

// Registered to line up with the RAM outputs
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_valid <= 1'b0;
                o_dirty <= 1'b0;
        end
        else
        begin
                o_valid <= fwd || (!bus.clear && valid[bus.rd_idx]);
                o_dirty <= fwd ? i_dirty : dirty[bus.rd_idx];
        end
end

endmodule

`default_nettype wire

//--- hw/dirty_scan.sv
`default_nettype none

// Lowest dirty set in one block of the dirty vector
module dirty_scan (
        input  wire cache_pkg::line_vec_t                     i_dirty_vec,
        input  wire logic [$clog2(cache_pkg::NUM_BLOCKS)-1:0] i_block,
        output logic                                          o_found,
        output cache_pkg::index_t                             o_idx
);

logic [cache_pkg::SCAN_BLOCK-1:0]         blk_bits;
logic [$clog2(cache_pkg::SCAN_BLOCK)-1:0] low;

always_comb
begin
        blk_bits = i_dirty_vec[i_block*cache_pkg::SCAN_BLOCK +: cache_pkg::SCAN_BLOCK];
        low      = '0;

        // Walk down so the lowest set bit is taken last
        for (int j = cache_pkg::SCAN_BLOCK - 1; j >= 0; j--)
        begin
                if (blk_bits[j])
                        low = j[$clog2(cache_pkg::SCAN_BLOCK)-1:0];
        end

        o_found = |blk_bits;
        // Block number forms the upper index bits
        o_idx   = {i_block, low};
end

endmodule

`default_nettype wire

//--- hw/clean_ctrl.sv
`default_nettype none

// Lookup sequencing plus global clean and invalidate
module clean_ctrl (
        input  wire logic                  i_clk,
        input  wire logic                  i_reset,
        input  wire cache_pkg::word_t      i_address_nxt,
        input  wire cache_pkg::word_t      i_address,
        input  wire logic                  i_tag_wr_en,
        input  wire logic                  i_clean_req,
        input  wire logic                  i_inv_req,
        input  wire cache_pkg::line_vec_t  i_dirty_vec,
        input  wire cache_pkg::line_t      i_line,
        input  wire cache_pkg::tag_entry_t i_tag,
        tag_ram_if.ctrl                    bus,
        output logic                       o_wb_cyc,
        output logic                       o_wb_stb,
        output logic                       o_wb_wen,
        output logic [3:0]                 o_wb_sel,
        output cache_pkg::word_t           o_wb_adr,
        output cache_pkg::word_t           o_wb_dat,
        output cache_pkg::cti_t            o_wb_cti,
        input  wire logic                  i_wb_ack,
        output logic                       o_clean_done,
        output logic                       o_inv_done
);

typedef enum logic [2:0] {
        S_IDLE,
        S_GET_ADDR,
        S_RD_WAIT0,
        S_RD_WAIT1,
        S_WRITE,
        S_INV
} state_t;

state_t                                       state;
state_t                                       state_nxt;
logic [$clog2(cache_pkg::NUM_BLOCKS)-1:0]     blk_ctr;
logic [$clog2(cache_pkg::NUM_BLOCKS)-1:0]     blk_nxt;
// One extra bit so a full line can be counted
logic [$clog2(cache_pkg::WORDS_PER_LINE):0]   word_ctr;
logic [$clog2(cache_pkg::WORDS_PER_LINE):0]   word_nxt;
logic [$clog2(cache_pkg::WORDS_PER_LINE):0]   word_inc;
logic [$clog2(cache_pkg::WORDS_PER_LINE)-1:0] wsel;
logic                                         wb_act;
cache_pkg::cti_t                              cti_nxt;
logic                                         found;
cache_pkg::index_t                            scan_idx;

dirty_scan u_dirty_scan (
        .i_dirty_vec (i_dirty_vec),
        .i_block     (blk_ctr),
        .o_found     (found),
        .o_idx       (scan_idx)
);

// Word count moves on each accepted beat
assign word_inc = word_ctr + (i_wb_ack && o_wb_stb);
assign wsel     = word_inc[$clog2(cache_pkg::WORDS_PER_LINE)-1:0];

// --------------------
// Next state
// --------------------

always_comb
begin
        state_nxt    = state;
        blk_nxt      = blk_ctr;
        word_nxt     = word_ctr;
        wb_act       = 1'b0;
        bus.rd_idx   = scan_idx;
        bus.wr_idx   = i_address[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
        bus.wr_en    = 1'b0;
        bus.clean    = 1'b0;
        bus.clear    = 1'b0;
        o_clean_done = 1'b0;
        o_inv_done   = 1'b0;

        case (state)
        S_IDLE:
        begin
                // Lookup and tag write pass straight through
                bus.rd_idx = i_address_nxt[cache_pkg::OFFSET_W +: cache_pkg::INDEX_W];
                bus.wr_en  = i_tag_wr_en;
                if (i_clean_req)
                begin
                        bus.wr_en = 1'b0;
                        blk_nxt   = '0;
                        state_nxt = S_GET_ADDR;
                end
                else if (i_inv_req)
                begin
                        bus.wr_en = 1'b0;
                        state_nxt = S_INV;
                end
        end

        S_GET_ADDR:
        begin
                word_nxt = '0;
                if (found)
                        state_nxt = S_RD_WAIT0;
                else
                begin
                        // Block has nothing left, step on or finish
                        blk_nxt = blk_ctr + 1'b1;
                        if (blk_ctr == cache_pkg::NUM_BLOCKS - 1)
                        begin
                                o_clean_done = 1'b1;
                                state_nxt    = S_IDLE;
                        end
                end
        end

        // Let the RAM outputs settle on the dirty set
        S_RD_WAIT0:
                state_nxt = S_RD_WAIT1;

        S_RD_WAIT1:
                state_nxt = S_WRITE;

        S_WRITE:
        begin
                word_nxt = word_inc;
                if (word_inc == cache_pkg::WORDS_PER_LINE)
                begin
                        // Last beat acked, line is clean
                        bus.clean = 1'b1;
                        state_nxt = S_GET_ADDR;
                end
                else
                        wb_act = 1'b1;
        end

        S_INV:
        begin
                bus.clear  = 1'b1;
                o_inv_done = 1'b1;
                state_nxt  = S_IDLE;
        end

        default:
                state_nxt = S_IDLE;
        endcase

        // Final beat closes the burst
        if (!wb_act)
                cti_nxt = cache_pkg::CTI_CLASSIC;
        else if (wsel == cache_pkg::WORDS_PER_LINE - 1)
                cti_nxt = cache_pkg::CTI_EOB;
        else
                cti_nxt = cache_pkg::CTI_BURST;
end

// --------------------
// Registers
// --------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state    <= S_IDLE;
                blk_ctr  <= '0;
                word_ctr <= '0;
                o_wb_cyc <= 1'b0;
                o_wb_stb <= 1'b0;
                o_wb_wen <= 1'b0;
                o_wb_cti <= cache_pkg::CTI_CLASSIC;
        end
        else
        begin
                state    <= state_nxt;
                blk_ctr  <= blk_nxt;
                word_ctr <= word_nxt;
                o_wb_cyc <= wb_act;
                o_wb_stb <= wb_act;
                o_wb_wen <= wb_act;
                o_wb_cti <= cti_nxt;
        end
end

// Beat payload, rebuilt every cycle so it holds until acked
always_ff @(posedge i_clk)
begin
        o_wb_sel <= {4{wb_act}};
        o_wb_adr <= wb_act ? {i_tag.pa_line, wsel, 2'b00} : '0;
        o_wb_dat <= wb_act ? i_line[wsel*32 +: 32] : '0;
end

endmodule

`default_nettype wire

//--- hw/cache_tag_ram.sv
`default_nettype none

// Direct-mapped tag and data store with its own write-back master
module cache_tag_ram (
        input  wire logic                  i_clk,
        input  wire logic                  i_reset,
        input  wire cache_pkg::word_t      i_address_nxt,
        input  wire cache_pkg::word_t      i_address,
        input  wire cache_pkg::line_t      i_cache_line,
        input  wire cache_pkg::line_ben_t  i_cache_line_ben,
        input  wire logic                  i_cache_tag_wr_en,
        input  wire cache_pkg::tag_entry_t i_cache_tag,
        input  wire logic                  i_cache_tag_dirty,
        input  wire logic                  i_cache_clean_req,
        input  wire logic                  i_cache_inv_req,
        output wire logic                  o_wb_cyc,
        output wire logic                  o_wb_stb,
        output wire logic                  o_wb_wen,
        output wire logic [3:0]            o_wb_sel,
        output wire cache_pkg::word_t      o_wb_adr,
        output wire cache_pkg::word_t      o_wb_dat,
        output wire cache_pkg::cti_t       o_wb_cti,
        input  wire logic                  i_wb_ack,
        output wire cache_pkg::line_t      o_cache_line,
        output wire cache_pkg::tag_entry_t o_cache_tag,
        output wire logic                  o_cache_tag_valid,
        output wire logic                  o_cache_tag_dirty,
        output wire logic                  o_cache_clean_done,
        output wire logic                  o_cache_inv_done
);

wire cache_pkg::line_vec_t dirty_vec;

tag_ram_if u_bus ();

// --------------------
// Control
// --------------------

clean_ctrl u_clean_ctrl (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_address_nxt (i_address_nxt),
        .i_address     (i_address),
        .i_tag_wr_en   (i_cache_tag_wr_en),
        .i_clean_req   (i_cache_clean_req),
        .i_inv_req     (i_cache_inv_req),
        .i_dirty_vec   (dirty_vec),
        .i_line        (o_cache_line),
        .i_tag         (o_cache_tag),
        .bus           (u_bus.ctrl),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb),
        .o_wb_wen      (o_wb_wen),
        .o_wb_sel      (o_wb_sel),
        .o_wb_adr      (o_wb_adr),
        .o_wb_dat      (o_wb_dat),
        .o_wb_cti      (o_wb_cti),
        .i_wb_ack      (i_wb_ack),
        .o_clean_done  (o_cache_clean_done),
        .o_inv_done    (o_cache_inv_done)
);

line_state u_line_state (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .bus         (u_bus.store),
        .i_dirty     (i_cache_tag_dirty),
        .o_valid     (o_cache_tag_valid),
        .o_dirty     (o_cache_tag_dirty),
        .o_dirty_vec (dirty_vec)
);

// --------------------
// Storage
// --------------------

// Tag entry, written only on a tag write strobe
line_ram #(
        .payload_t (cache_pkg::tag_entry_t)
) u_tag_ram (
        .i_clk     (i_clk),
        .bus       (u_bus.store),
        .i_wr_en   (u_bus.wr_en),
        .i_wr_data (i_cache_tag),
        .o_rd_data (o_cache_tag)
);

// One byte lane per enable bit
for (genvar i = 0; i < cache_pkg::LINE_BYTES; i++)
begin : g_lane
        line_ram #(
                .payload_t (logic [7:0])
        ) u_data_ram (
                .i_clk     (i_clk),
                .bus       (u_bus.store),
                .i_wr_en   (i_cache_line_ben[i]),
                .i_wr_data (i_cache_line[i*8 +: 8]),
                .o_rd_data (o_cache_line[i*8 +: 8])
        );
end

endmodule

`default_nettype wire

//--- dv/clk_gen.sv
`default_nettype none

// Free running clock with a reset held for a fixed number of cycles
module clk_gen #(
        parameter int PERIOD       = 4,
        parameter int RESET_CYCLES = 16
) (
        output logic o_clk,
        output logic o_reset
);

initial
begin
        o_clk = 1'b0;
        forever
                #(PERIOD / 2) o_clk = ~o_clk;
end

// Released on a rising edge, like any other input
initial
begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES)
                @(posedge o_clk);
        o_reset <= 1'b0;
end

endmodule

`default_nettype wire

//--- dv/cache_tag_ram_tb.sv
`default_nettype none

module cache_tag_ram_tb;

localparam int unsigned SEED          = 32'hee607ca1;
localparam int          RESET_TIMEOUT = 64;
localparam int          CLEAN_TIMEOUT = 2000;
localparam int          RUN_CYCLES    = 20000;

typedef enum {
        OP_WRITE,
        OP_LINE,
        OP_LOOKUP,
        OP_SWEEP,
        OP_CLEAN,
        OP_INV
} op_t;

// One stimulus step and what it must produce
typedef struct {
        op_t                  kind;
        int                   idx;
        cache_pkg::line_ben_t ben;
        logic                 dirty;
        logic                 exp_valid;
        logic                 exp_dirty;
        int                   exp_words;
} row_t;

logic                  clk;
logic                  reset;
cache_pkg::word_t      address_nxt;
cache_pkg::word_t      address;
cache_pkg::line_t      line_in;
cache_pkg::line_ben_t  line_ben;
logic                  tag_wr_en;
cache_pkg::tag_entry_t tag_in;
logic                  tag_dirty;
logic                  clean_req;
logic                  inv_req;
logic                  wb_ack;
logic                  wb_cyc;
logic                  wb_stb;
logic                  wb_wen;
logic [3:0]            wb_sel;
cache_pkg::word_t      wb_adr;
cache_pkg::word_t      wb_dat;
cache_pkg::cti_t       wb_cti;
cache_pkg::line_t      look_line;
cache_pkg::tag_entry_t look_tag;
logic                  look_valid;
logic                  look_dirty;
logic                  clean_done;
logic                  inv_done;

// Shadow copy of the store
cache_pkg::tag_entry_t sh_tag   [cache_pkg::NUM_LINES];
cache_pkg::line_t      sh_line  [cache_pkg::NUM_LINES];
logic                  sh_valid [cache_pkg::NUM_LINES];
logic                  sh_dirty [cache_pkg::NUM_LINES];
logic                  sh_known [cache_pkg::NUM_LINES];

// Bus slave state and the words it has taken
logic                  ack_plan;
int                    ack_delay;
int                    cyc_seen;
cache_pkg::word_t      log_adr [$];
cache_pkg::word_t      log_dat [$];
cache_pkg::cti_t       log_cti [$];

row_t                  ops [$];

clk_gen #(
        .PERIOD       (4),
        .RESET_CYCLES (16)
) u_clk_gen (
        .o_clk   (clk),
        .o_reset (reset)
);

cache_tag_ram u_cache_tag_ram (
        .i_clk              (clk),
        .i_reset            (reset),
        .i_address_nxt      (address_nxt),
        .i_address          (address),
        .i_cache_line       (line_in),
        .i_cache_line_ben   (line_ben),
        .i_cache_tag_wr_en  (tag_wr_en),
        .i_cache_tag        (tag_in),
        .i_cache_tag_dirty  (tag_dirty),
        .i_cache_clean_req  (clean_req),
        .i_cache_inv_req    (inv_req),
        .o_wb_cyc           (wb_cyc),
        .o_wb_stb           (wb_stb),
        .o_wb_wen           (wb_wen),
        .o_wb_sel           (wb_sel),
        .o_wb_adr           (wb_adr),
        .o_wb_dat           (wb_dat),
        .o_wb_cti           (wb_cti),
        .i_wb_ack           (wb_ack),
        .o_cache_line       (look_line),
        .o_cache_tag        (look_tag),
        .o_cache_tag_valid  (look_valid),
        .o_cache_tag_dirty  (look_dirty),
        .o_cache_clean_done (clean_done),
        .o_cache_inv_done   (inv_done)
);

// --------------------
// Error reporting
// --------------------

task automatic report_mismatch(input string msg);
begin
        $display("FAIL @%0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "value mismatch");
end
endtask

task automatic report_error(input string msg);
begin
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run aborted");
end
endtask

task automatic check_tag(input cache_pkg::tag_entry_t exp, input cache_pkg::tag_entry_t got,
                         input string what);
begin
        if (got !== exp)
                report_mismatch($sformatf("%s tag %h, expected %h", what, got, exp));
end
endtask

task automatic check_line(input cache_pkg::line_t exp, input cache_pkg::line_t got,
                          input string what);
begin
        if (got !== exp)
                report_mismatch($sformatf("%s line %h, expected %h", what, got, exp));
end
endtask

task automatic check_bit(input logic exp, input logic got, input string what);
begin
        if (got !== exp)
                report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
end
endtask

task automatic check_beat(input cache_pkg::word_t exp_adr, input cache_pkg::word_t exp_dat,
                          input cache_pkg::cti_t exp_cti, input cache_pkg::word_t got_adr,
                          input cache_pkg::word_t got_dat, input cache_pkg::cti_t got_cti,
                          input int n);
begin
        if (got_adr !== exp_adr || got_dat !== exp_dat || got_cti !== exp_cti)
                report_mismatch($sformatf("bus word %0d adr %h dat %h cti %b, expected %h %h %b",
                                          n, got_adr, got_dat, got_cti,
                                          exp_adr, exp_dat, exp_cti));
end
endtask

// --------------------
// Wishbone slave
// --------------------

// Decide at the falling edge, drive at the rising edge
always @(negedge clk)
begin
        if (!reset)
        begin
                if (wb_cyc)
                        cyc_seen++;
                if (wb_ack && wb_stb)
                begin
                        // Word is taken at the coming rising edge
                        check_bit(1'b1, wb_cyc, "bus cycle with accepted word");
                        check_bit(1'b1, wb_sel == 4'hf, "bus select all ones");
                        check_bit(1'b1, wb_wen, "bus write enable");
                        log_adr.push_back(wb_adr);
                        log_dat.push_back(wb_dat);
                        log_cti.push_back(wb_cti);
                        ack_plan  = 1'b0;
                        ack_delay = $urandom % 4;
                end
                else if (wb_stb)
                begin
                        if (ack_delay == 0)
                                ack_plan = 1'b1;
                        else
                                ack_delay--;
                end
                else
                        ack_plan = 1'b0;
        end
end

always @(posedge clk)
begin
        if (reset)
                wb_ack <= 1'b0;
        else
                wb_ack <= ack_plan;
end

// --------------------
// Operations
// --------------------

task automatic add_row(input op_t kind, input int idx, input cache_pkg::line_ben_t ben,
                       input logic dirty, input logic exp_v, input logic exp_d,
                       input int exp_words);
begin
        ops.push_back('{kind, idx, ben, dirty, exp_v, exp_d, exp_words});
end
endtask

// Tag write with line write, or a line write alone
task automatic write_entry(input int idx, input cache_pkg::line_ben_t ben, input logic dirty,
                           input logic with_tag);
        cache_pkg::tag_entry_t tag;
        cache_pkg::line_t      data;
        cache_pkg::word_t      adr;
begin
        tag.va_tag  = $urandom;
        tag.pa_line = $urandom;
        data        = {$urandom, $urandom, $urandom, $urandom};
        adr         = cache_pkg::word_t'(idx) << cache_pkg::OFFSET_W;
        @(posedge clk);
        address     <= adr;
        address_nxt <= adr;
        line_in     <= data;
        line_ben    <= ben;
        tag_wr_en   <= with_tag;
        tag_in      <= tag;
        tag_dirty   <= dirty;
        @(posedge clk);
        line_ben    <= '0;
        tag_wr_en   <= 1'b0;
        tag_dirty   <= 1'b0;
        @(negedge clk);
        // Same-index lookup sees the new bits straight away
        if (with_tag)
        begin
                check_bit(1'b1, look_valid, $sformatf("forwarded valid of set %0d", idx));
                check_bit(dirty, look_dirty, $sformatf("forwarded dirty of set %0d", idx));
        end
        for (int b = 0; b < cache_pkg::LINE_BYTES; b++)
        begin
                if (ben[b])
                        sh_line[idx][b*8 +: 8] = data[b*8 +: 8];
        end
        if (with_tag)
        begin
                sh_tag[idx]   = tag;
                sh_valid[idx] = 1'b1;
                sh_dirty[idx] = dirty;
                sh_known[idx] = 1'b1;
        end
end
endtask

task automatic lookup(input int idx, input logic exp_v, input logic exp_d);
        cache_pkg::word_t adr;
begin
        adr = cache_pkg::word_t'(idx) << cache_pkg::OFFSET_W;
        @(posedge clk);
        address_nxt <= adr;
        @(posedge clk);
        @(negedge clk);
        check_bit(exp_v, look_valid, $sformatf("valid of set %0d", idx));
        check_bit(exp_d, look_dirty, $sformatf("dirty of set %0d", idx));
        // RAM contents are only known once written
        if (sh_known[idx])
        begin
                check_tag(sh_tag[idx], look_tag, $sformatf("set %0d", idx));
                check_line(sh_line[idx], look_line, $sformatf("set %0d", idx));
        end
end
endtask

task automatic run_clean(input int exp_words);
        cache_pkg::word_t exp_adr [$];
        cache_pkg::word_t exp_dat [$];
        cache_pkg::cti_t  exp_cti [$];
        logic             seen;
begin
        // Four words for every dirty set, lowest set first
        for (int i = 0; i < cache_pkg::NUM_LINES; i++)
        begin
                if (sh_dirty[i])
                begin
                        for (int k = 0; k < cache_pkg::WORDS_PER_LINE; k++)
                        begin
                                exp_adr.push_back((cache_pkg::word_t'(sh_tag[i].pa_line) << 4)
                                                  + cache_pkg::word_t'(4 * k));
                                exp_dat.push_back(sh_line[i][k*32 +: 32]);
                                exp_cti.push_back(k == cache_pkg::WORDS_PER_LINE - 1 ?
                                                  cache_pkg::CTI_EOB : cache_pkg::CTI_BURST);
                        end
                end
        end
        if (exp_adr.size() != exp_words)
                report_error("Stimulus table and shadow model disagree on the clean size");
        log_adr.delete();
        log_dat.delete();
        log_cti.delete();
        cyc_seen = 0;
        seen     = 1'b0;
        @(posedge clk);
        clean_req <= 1'b1;
        @(posedge clk);
        clean_req <= 1'b0;
        for (int t = 0; t < CLEAN_TIMEOUT && !seen; t++)
        begin
                @(negedge clk);
                seen = clean_done;
        end
        if (!seen)
                report_error("Timed out waiting for the clean done pulse");
        check_bit(1'b0, wb_cyc, "bus cycle at clean done");
        @(negedge clk);
        check_bit(1'b0, clean_done, "clean done one cycle later");
        if (log_adr.size() != exp_words)
                report_mismatch($sformatf("clean sent %0d words, expected %0d",
                                          log_adr.size(), exp_words));
        if (exp_words == 0 && cyc_seen != 0)
                report_mismatch("bus cycle raised with no dirty line");
        for (int n = 0; n < exp_words; n++)
                check_beat(exp_adr[n], exp_dat[n], exp_cti[n], log_adr[n], log_dat[n],
                           log_cti[n], n);
        for (int i = 0; i < cache_pkg::NUM_LINES; i++)
                sh_dirty[i] = 1'b0;
end
endtask

task automatic run_invalidate;
begin
        @(posedge clk);
        inv_req <= 1'b1;
        @(posedge clk);
        inv_req <= 1'b0;
        // Done is due in the cycle right after the request is taken
        @(negedge clk);
        check_bit(1'b1, inv_done, "invalidate done");
        @(negedge clk);
        check_bit(1'b0, inv_done, "invalidate done one cycle later");
        for (int i = 0; i < cache_pkg::NUM_LINES; i++)
                sh_valid[i] = 1'b0;
end
endtask

task automatic apply_row(input row_t row);
begin
        case (row.kind)
        OP_WRITE:
                write_entry(row.idx, row.ben, row.dirty, 1'b1);
        OP_LINE:
                write_entry(row.idx, row.ben, 1'b0, 1'b0);
        OP_LOOKUP:
                lookup(row.idx, row.exp_valid, row.exp_dirty);
        OP_SWEEP:
        begin
                for (int i = 0; i < cache_pkg::NUM_LINES; i++)
                        lookup(i, sh_valid[i], sh_dirty[i]);
        end
        OP_CLEAN:
                run_clean(row.exp_words);
        OP_INV:
                run_invalidate();
        default:
                report_error("Unknown operation in the stimulus table");
        endcase
end
endtask

// --------------------
// Stimulus table
// --------------------

task automatic build_ops;
begin
        // Empty after reset
        add_row(OP_SWEEP,  0,  '0,       1'b0, 1'b0, 1'b0, 0);
        // Full writes and lookups
        add_row(OP_WRITE,  3,  16'hffff, 1'b1, 1'b0, 1'b0, 0);
        add_row(OP_LOOKUP, 3,  '0,       1'b0, 1'b1, 1'b1, 0);
        add_row(OP_WRITE,  20, 16'hffff, 1'b0, 1'b0, 1'b0, 0);
        add_row(OP_LOOKUP, 20, '0,       1'b0, 1'b1, 1'b0, 0);
        add_row(OP_WRITE,  17, 16'hffff, 1'b1, 1'b0, 1'b0, 0);
        add_row(OP_WRITE,  50, 16'hffff, 1'b1, 1'b0, 1'b0, 0);
        add_row(OP_WRITE,  63, 16'hffff, 1'b1, 1'b0, 1'b0, 0);
        // Partial line writes
        add_row(OP_LINE,   3,  16'h0f0f, 1'b0, 1'b0, 1'b0, 0);
        add_row(OP_LOOKUP, 3,  '0,       1'b0, 1'b1, 1'b1, 0);
        add_row(OP_LINE,   20, 16'h8001, 1'b0, 1'b0, 1'b0, 0);
        add_row(OP_LOOKUP, 20, '0,       1'b0, 1'b1, 1'b0, 0);
        // Tag rewrite drops the dirty flag
        add_row(OP_WRITE,  50, 16'hffff, 1'b0, 1'b0, 1'b0, 0);
        add_row(OP_LOOKUP, 50, '0,       1'b0, 1'b1, 1'b0, 0);
        // Sets 3, 17 and 63 go out
        add_row(OP_CLEAN,  0,  '0,       1'b0, 1'b0, 1'b0, 12);
        add_row(OP_LOOKUP, 3,  '0,       1'b0, 1'b1, 1'b0, 0);
        add_row(OP_LOOKUP, 17, '0,       1'b0, 1'b1, 1'b0, 0);
        add_row(OP_LOOKUP, 63, '0,       1'b0, 1'b1, 1'b0, 0);
        add_row(OP_LOOKUP, 50, '0,       1'b0, 1'b1, 1'b0, 0);
        add_row(OP_CLEAN,  0,  '0,       1'b0, 1'b0, 1'b0, 0);
        // Invalidate leaves dirty bits alone
        add_row(OP_WRITE,  9,  16'hffff, 1'b1, 1'b0, 1'b0, 0);
        add_row(OP_INV,    0,  '0,       1'b0, 1'b0, 1'b0, 0);
        add_row(OP_SWEEP,  0,  '0,       1'b0, 1'b0, 1'b0, 0);
        add_row(OP_LOOKUP, 9,  '0,       1'b0, 1'b0, 1'b1, 0);
        add_row(OP_CLEAN,  0,  '0,       1'b0, 1'b0, 1'b0, 4);
        add_row(OP_LOOKUP, 9,  '0,       1'b0, 1'b0, 1'b0, 0);
        add_row(OP_WRITE,  40, 16'hffff, 1'b1, 1'b0, 1'b0, 0);
        add_row(OP_LOOKUP, 40, '0,       1'b0, 1'b1, 1'b1, 0);
end
endtask

// --------------------
// Main sequence
// --------------------

initial
begin
        void'($urandom(SEED));
        address_nxt = '0;
        address     = '0;
        line_in     = '0;
        line_ben    = '0;
        tag_wr_en   = 1'b0;
        tag_in      = '0;
        tag_dirty   = 1'b0;
        clean_req   = 1'b0;
        inv_req     = 1'b0;
        wb_ack      = 1'b0;
        ack_plan    = 1'b0;
        ack_delay   = $urandom % 4;
        cyc_seen    = 0;
        for (int i = 0; i < cache_pkg::NUM_LINES; i++)
        begin
                sh_valid[i] = 1'b0;
                sh_dirty[i] = 1'b0;
                sh_known[i] = 1'b0;
        end
        build_ops();

        for (int t = 0; t < RESET_TIMEOUT && reset; t++)
                @(negedge clk);
        if (reset)
                report_error("Reset was never released");

        // Idle bus and no pulses out of reset
        check_bit(1'b0, wb_cyc, "bus cycle after reset");
        check_bit(1'b0, wb_stb, "bus strobe after reset");
        check_bit(1'b0, clean_done, "clean done after reset");
        check_bit(1'b0, inv_done, "invalidate done after reset");
        check_bit(1'b1, wb_cti == cache_pkg::CTI_CLASSIC, "classic cycle type after reset");

        foreach (ops[r])
                apply_row(ops[r]);

        $display("Simulation completed successfully");
        $finish;
end

// Hard limit on the whole run
initial
begin
        repeat (RUN_CYCLES)
                @(posedge clk);
        report_error("Run went past its cycle limit");
end

endmodule

`default_nettype wire

//--- tb.f
hw/cache_pkg.sv
hw/tag_ram_if.sv
hw/line_ram.sv
hw/line_state.sv
hw/dirty_scan.sv
hw/clean_ctrl.sv
hw/cache_tag_ram.sv
dv/clk_gen.sv
dv/cache_tag_ram_tb.sv

//--- Bender.yml
package:
  name: cache_tag_ram

sources:
  - hw/cache_pkg.sv
  - hw/tag_ram_if.sv
  - hw/line_ram.sv
  - hw/line_state.sv
  - hw/dirty_scan.sv
  - hw/clean_ctrl.sv
  - hw/cache_tag_ram.sv
  - target: test
    files:
      - dv/clk_gen.sv
      - dv/cache_tag_ram_tb.sv
